/* Bender.yml */
package:
  name: dlx_ex

sources:
  - design/dlx_pkg.sv
  - design/dlx_ifs.sv
  - design/dlx_alu.sv
  - design/booth_mult.sv
  - design/operand_issue.sv
  - design/ex_stage.sv
  - design/mem_wb_stage.sv
  - design/dlx_ex_top.sv
  - target: test
    files:
      - tb/tb_dlx_ex.sv

/* design/booth_mult.sv */
`timescale 1ns/100ps

module booth_mult import dlx_pkg::*; #(
    parameter int MULT_RADIX_STEPS = 16   // at least WORD_W/2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        is_signed,
    input  word_t       a,
    input  word_t       b,
    output logic        busy,
    output logic        done,
    output logic [0:63] product
);

    localparam int MW    = 2 * MULT_RADIX_STEPS;   // recoded multiplier width
    localparam int PW    = 2 * WORD_W;
    localparam int CNT_W = $clog2(MULT_RADIX_STEPS + 1);

    logic [0:PW-1]    acc;
    logic [0:PW-1]    mcand;
    logic [0:PW-1]    a_ext;
    logic [0:PW-1]    pp;
    logic [0:MW-1]    b_ext;
    logic [0:MW]      mplier;       // extra zero below the lsb
    logic [0:CNT_W-1] steps_left;

    assign a_ext = is_signed ? PW'(signed'(a)) : PW'(a);
    assign b_ext = is_signed ? MW'(signed'(b)) : MW'(b);

    // one radix-4 digit per cycle
    always_comb
    begin
        case (mplier[MW-2:MW])
            3'b001, 3'b010: pp = mcand;
            3'b011:         pp = mcand << 1;
            3'b100:         pp = -(mcand << 1);
            3'b101, 3'b110: pp = -mcand;
            default:        pp = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy       <= 1'b0;
            done       <= 1'b0;
            steps_left <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy       <= 1'b1;
                steps_left <= CNT_W'(MULT_RADIX_STEPS);
            end
            else if (busy)
            begin
                steps_left <= steps_left - 1'b1;
                if (steps_left == CNT_W'(1))
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // unsigned with msb set needs the top digit that the recoding drops
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            acc    <= (!is_signed && b_ext[0]) ? (a_ext << MW) : '0;
            mcand  <= a_ext;
            mplier <= {b_ext, 1'b0};
        end
        else if (busy)
        begin
            acc    <= acc + pp;
            mcand  <= mcand << 2;
            mplier <= mplier >> 2;
        end
    end

    assign product = acc;

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !start);

endmodule

/* design/dlx_alu.sv */
`timescale 1ns/100ps

module dlx_alu import dlx_pkg::*; (
    input  word_t     a,
    input  word_t     b,
    input  alu_func_e func,
    output word_t     result
);

    logic [0:4] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[27:31];   // low 5 bits
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb
    begin
        case (func)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND_OP:  result = a & b;
            OR_OP:   result = a | b;
            XOR_OP:  result = a ^ b;
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = word_t'($signed(a) >>> shamt);
            SLT:     result = word_t'(lt_s);
            SLTU:    result = word_t'(lt_u);
            LHI:     result = b << 16;
            default: result = '0;   // multiplies go through booth_mult
        endcase
    end

endmodule

/* design/dlx_ex_top.sv */
`timescale 1ns/100ps

module dlx_ex_top import dlx_pkg::*; #(
    parameter int MULT_RADIX_STEPS = 16
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  alu_func_e issue_func,
    input  reg_idx_t  issue_rd,
    input  reg_idx_t  issue_rs1,
    input  reg_idx_t  issue_rs2,
    input  word_t     issue_imm,
    input  logic      issue_use_imm,
    output logic      stall,
    output logic      wb_valid,
    output reg_idx_t  wb_rd,
    output word_t     wb_data
);

    logic     ex_valid;
    reg_idx_t ex_rd;
    word_t    ex_result;

    issue_bus_if iss ();
    fwd_bus_if   fwd ();

    operand_issue u_issue (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .issue_func    (issue_func),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_imm     (issue_imm),
        .issue_use_imm (issue_use_imm),
        .stall         (stall),
        .fwd           (fwd.dst),
        .iss           (iss.src)
    );

    ex_stage #(
        .MULT_RADIX_STEPS (MULT_RADIX_STEPS)
    ) u_ex (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss       (iss.dst),
        .fwd       (fwd.dst),
        .stall     (stall),
        .ex_valid  (ex_valid),
        .ex_rd     (ex_rd),
        .ex_result (ex_result)
    );

    mem_wb_stage u_mem_wb (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_valid  (ex_valid),
        .ex_rd     (ex_rd),
        .ex_result (ex_result),
        .fwd       (fwd.src),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

/* design/dlx_ifs.sv */
`timescale 1ns/100ps

interface issue_bus_if import dlx_pkg::*; ();
    logic      valid;
    alu_func_e func;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    word_t     a_val;    // register file value of rs1
    word_t     b_val;    // register file value of rs2
    word_t     imm;
    logic      use_imm;

    modport src (output valid, func, rd, rs1, rs2, a_val, b_val, imm, use_imm);
    modport dst (input  valid, func, rd, rs1, rs2, a_val, b_val, imm, use_imm);
endinterface

interface fwd_bus_if import dlx_pkg::*; ();
    logic     mem_valid;
    reg_idx_t mem_rd;
    word_t    mem_data;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    modport src (output mem_valid, mem_rd, mem_data, wb_valid, wb_rd, wb_data);
    modport dst (input  mem_valid, mem_rd, mem_data, wb_valid, wb_rd, wb_data);
endinterface

/* design/dlx_pkg.sv */
package dlx_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int WORD_W    = 32;
    localparam int NUM_REGS  = 32;
    localparam int REG_IDX_W = 5;

    // bit 0 is the msb on every bus
    typedef logic [0:WORD_W-1]    word_t;
    typedef logic [0:REG_IDX_W-1] reg_idx_t;

    // ==================================================
    // function codes
    // ==================================================
    typedef enum logic [0:5] {
        SLL    = 6'h04,
        SRL    = 6'h06,
        SRA    = 6'h07,
        MULT   = 6'h0e,   // signed low word
        LHI    = 6'h0f,
        MULTHU = 6'h16,   // unsigned high word
        ADD    = 6'h20,
        SUB    = 6'h22,
        AND_OP = 6'h24,
        OR_OP  = 6'h25,
        XOR_OP = 6'h26,
        SLT    = 6'h2a,
        SLTU   = 6'h3a
    } alu_func_e;

    function automatic logic is_mult(input alu_func_e func);
        return (func == MULT) || (func == MULTHU);
    endfunction

endpackage

/* design/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage import dlx_pkg::*; #(
    parameter int MULT_RADIX_STEPS = 16
) (
    input  logic     clk,
    input  logic     rst_n,
    issue_bus_if.dst iss,
    fwd_bus_if.dst   fwd,
    output logic     stall,
    output logic     ex_valid,
    output reg_idx_t ex_rd,
    output word_t    ex_result
);

    word_t       op_a;
    word_t       op_b;
    word_t       fwd_b;
    word_t       alu_result;
    word_t       mult_word;
    logic [0:63] product;
    logic        ex_wr;
    logic        mem_wr;
    logic        wb_wr;
    logic        a_hit_ex;
    logic        a_hit_mem;
    logic        a_hit_wb;
    logic        b_hit_ex;
    logic        b_hit_mem;
    logic        b_hit_wb;
    logic        mult_in_ex;
    logic        mult_start;
    logic        mult_busy;
    logic        mult_done;
    logic        started;

    // ==================================================
    // forwarding with the youngest producer first
    // ==================================================
    assign ex_wr  = ex_valid && (ex_rd != '0);
    assign mem_wr = fwd.mem_valid && (fwd.mem_rd != '0);
    assign wb_wr  = fwd.wb_valid && (fwd.wb_rd != '0);

    assign a_hit_ex  = ex_wr  && (ex_rd == iss.rs1);     // own EX/MEM register
    assign a_hit_mem = mem_wr && (fwd.mem_rd == iss.rs1);
    assign a_hit_wb  = wb_wr  && (fwd.wb_rd == iss.rs1);
    assign b_hit_ex  = ex_wr  && (ex_rd == iss.rs2);
    assign b_hit_mem = mem_wr && (fwd.mem_rd == iss.rs2);
    assign b_hit_wb  = wb_wr  && (fwd.wb_rd == iss.rs2);

    assign op_a  = a_hit_ex  ? ex_result    :
                   a_hit_mem ? fwd.mem_data :
                   a_hit_wb  ? fwd.wb_data  : iss.a_val;
    assign fwd_b = b_hit_ex  ? ex_result    :
                   b_hit_mem ? fwd.mem_data :
                   b_hit_wb  ? fwd.wb_data  : iss.b_val;
    assign op_b  = iss.use_imm ? iss.imm : fwd_b;

    dlx_alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .func   (iss.func),
        .result (alu_result)
    );

    // ==================================================
    // multiplier sequencing
    // ==================================================
    assign mult_in_ex = iss.valid && is_mult(iss.func);
    assign mult_start = mult_in_ex && !started;   // once per multiply
    assign stall      = mult_in_ex && !mult_done;
    assign mult_word  = (iss.func == MULT) ? product[32:63] : product[0:31];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            started <= 1'b0;
        else if (mult_done)
            started <= 1'b0;
        else if (mult_start)
            started <= 1'b1;
    end

    booth_mult #(
        .MULT_RADIX_STEPS (MULT_RADIX_STEPS)
    ) u_mult (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (mult_start),
        .is_signed (iss.func == MULT),
        .a         (op_a),
        .b         (op_b),
        .busy      (mult_busy),
        .done      (mult_done),
        .product   (product)
    );

    // EX/MEM register takes a bubble while stalled
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ex_valid <= 1'b0;
        else
            ex_valid <= iss.valid && !stall;
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            ex_rd     <= iss.rd;
            ex_result <= mult_in_ex ? mult_word : alu_result;
        end
    end

    a_stall_mult: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> iss.valid && is_mult(iss.func) && (mult_start || mult_busy));

    a_no_r0_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        iss.valid |-> (iss.rs1 != '0 || op_a == '0) && (iss.rs2 != '0 || fwd_b == '0));

endmodule

/* design/mem_wb_stage.sv */
`timescale 1ns/100ps

module mem_wb_stage import dlx_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ex_valid,
    input  reg_idx_t ex_rd,
    input  word_t    ex_result,
    fwd_bus_if.src   fwd,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    logic     slot_valid;
    reg_idx_t slot_rd;
    word_t    slot_data;

    // memory slot is a plain delay without data memory
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            slot_valid <= 1'b0;
            wb_valid   <= 1'b0;
        end
        else
        begin
            slot_valid <= ex_valid;
            wb_valid   <= slot_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        slot_rd   <= ex_rd;
        slot_data <= ex_result;
        wb_rd     <= slot_rd;
        wb_data   <= slot_data;
    end

    assign fwd.mem_valid = slot_valid;
    assign fwd.mem_rd    = slot_rd;
    assign fwd.mem_data  = slot_data;
    assign fwd.wb_valid  = wb_valid;   // also the register file write
    assign fwd.wb_rd     = wb_rd;
    assign fwd.wb_data   = wb_data;

endmodule

/* design/operand_issue.sv */
`timescale 1ns/100ps

module operand_issue import dlx_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  alu_func_e issue_func,
    input  reg_idx_t  issue_rd,
    input  reg_idx_t  issue_rs1,
    input  reg_idx_t  issue_rs2,
    input  word_t     issue_imm,
    input  logic      issue_use_imm,
    input  logic      stall,
    fwd_bus_if.dst    fwd,
    issue_bus_if.src  iss
);

    word_t rf [NUM_REGS];
    word_t rd_a;
    word_t rd_b;
    logic  rf_we;

    assign rf_we = fwd.wb_valid && (fwd.wb_rd != '0);   // r0 is never written

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                rf[i] <= '0;
        end
        else if (rf_we)
        begin
            rf[fwd.wb_rd] <= fwd.wb_data;
        end
    end

    // write-first read where the pending writeback wins over the array
    assign rd_a = (issue_rs1 == '0)                   ? '0          :
                  (rf_we && fwd.wb_rd == issue_rs1)   ? fwd.wb_data : rf[issue_rs1];
    assign rd_b = (issue_rs2 == '0)                   ? '0          :
                  (rf_we && fwd.wb_rd == issue_rs2)   ? fwd.wb_data : rf[issue_rs2];

    // ==================================================
    // issue register held while stalled
    // ==================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            iss.valid <= 1'b0;
        else if (!stall)
            iss.valid <= issue_valid;
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            iss.func    <= issue_func;
            iss.rd      <= issue_rd;
            iss.rs1     <= issue_rs1;
            iss.rs2     <= issue_rs2;
            iss.a_val   <= rd_a;
            iss.b_val   <= rd_b;
            iss.imm     <= issue_imm;
            iss.use_imm <= issue_use_imm;
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && issue_valid) |=> issue_valid && $stable(issue_func) && $stable(issue_rd)
            && $stable(issue_rs1) && $stable(issue_rs2) && $stable(issue_imm)
            && $stable(issue_use_imm));

endmodule

/* dlx_ex.f */
design/dlx_pkg.sv
design/dlx_ifs.sv
design/dlx_alu.sv
design/booth_mult.sv
design/operand_issue.sv
design/ex_stage.sv
design/mem_wb_stage.sv
design/dlx_ex_top.sv
tb/tb_dlx_ex.sv

/* tb/dlx_ex_tests.txt */
add_imm 20 1 0 0 00000005 1 00000005
add_neg 20 2 0 0 fffffffd 1 fffffffd
or_imm 25 3 0 0 0000f0f0 1 0000f0f0
lhi_imm 0f 4 0 0 00001234 1 12340000
sub_fwd 22 5 4 3 00000000 0 12330f10
xor_fwd 26 6 5 1 00000000 0 12330f15
sll_imm 04 7 1 0 00000024 1 00000050
srl_imm 06 8 2 0 0000001c 1 0000000f
sra_imm 07 9 2 0 00000001 1 fffffffe
slt_reg 2a 10 2 1 00000000 0 00000001
sltu_reg 3a 11 2 1 00000000 0 00000000
add_dist3 20 12 9 7 00000000 0 0000004e
add_dist4 20 13 9 8 00000000 0 0000000d
and_reg 24 22 6 3 00000000 0 00000010
mult_neg 0e 14 2 1 00000000 0 fffffff1
add_after_mult 20 15 14 0 00000001 1 fffffff2
multhu_neg 16 16 2 2 00000000 0 fffffffa
mult_large 0e 17 4 3 00000000 0 d0c00000
multhu_large 16 18 4 2 00000000 0 1233ffff
mult_fwd 0e 19 18 1 00000000 0 5b03fffb
add_r0 20 0 1 0 00000077 1 0000007c
or_r0 25 20 0 0 00000000 0 00000000
add_r0_imm 20 21 0 0 00000011 1 00000011

/* tb/tb_dlx_ex.sv */
`timescale 1ns/100ps

module tb_dlx_ex import dlx_pkg::*; ();

    localparam int MAX_TESTS     = 64;
    localparam int NAME_W        = 8 * 24;
    localparam int STALL_TIMEOUT = 200;   // longer than one multiply
    localparam int DRAIN_TIMEOUT = 300;
    localparam int QUIET_CYCLES  = 10;

    logic      clk;
    logic      rst_n;
    logic      issue_valid;
    alu_func_e issue_func;
    reg_idx_t  issue_rd;
    reg_idx_t  issue_rs1;
    reg_idx_t  issue_rs2;
    word_t     issue_imm;
    logic      issue_use_imm;
    logic      stall;
    logic      wb_valid;
    reg_idx_t  wb_rd;
    word_t     wb_data;

    // ==================================================
    // test table filled from tb/dlx_ex_tests.txt
    // ==================================================
    logic [NAME_W-1:0] t_name    [MAX_TESTS];
    alu_func_e         t_func    [MAX_TESTS];
    reg_idx_t          t_rd      [MAX_TESTS];
    reg_idx_t          t_rs1     [MAX_TESTS];
    reg_idx_t          t_rs2     [MAX_TESTS];
    word_t             t_imm     [MAX_TESTS];
    logic              t_use_imm [MAX_TESTS];
    word_t             t_exp     [MAX_TESTS];

    int num_tests;
    int pass_count;
    int fail_count;
    int error_count;
    int stall_cycles;
    int mult_count;
    int exp_idx_q [$];   // accepted tests in issue order

    dlx_ex_top #(
        .MULT_RADIX_STEPS (16)
    ) dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .issue_func    (issue_func),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_imm     (issue_imm),
        .issue_use_imm (issue_use_imm),
        .stall         (stall),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input logic [NAME_W-1:0] name, input word_t expected,
                              input word_t actual, output logic ok);
        ok = (actual === expected);
        if (!ok)
            $display("FAILED %0s: data expected %h, actual %h", name, expected, actual);
    endtask

    task automatic check_reg(input logic [NAME_W-1:0] name, input reg_idx_t expected,
                             input reg_idx_t actual, output logic ok);
        ok = (actual === expected);
        if (!ok)
            $display("FAILED %0s: rd expected %0d, actual %0d", name, expected, actual);
    endtask

    // writebacks are sampled before the edge updates them
    always @(posedge clk)
    begin : wb_monitor
        int   idx;
        logic rd_ok;
        logic data_ok;
        if (rst_n && stall)
            stall_cycles++;
        if (rst_n && wb_valid)
        begin
            if (exp_idx_q.size() == 0)
            begin
                $display("unexpected writeback to r%0d with data %h", wb_rd, wb_data);
                error_count++;
            end
            else
            begin
                idx = exp_idx_q.pop_front();
                check_reg(t_name[idx], t_rd[idx], wb_rd, rd_ok);
                check_word(t_name[idx], t_exp[idx], wb_data, data_ok);
                if (rd_ok && data_ok)
                begin
                    $display("passed %0s: r%0d = %h", t_name[idx], wb_rd, wb_data);
                    pass_count++;
                end
                else
                    fail_count++;
            end
        end
    end

    task automatic load_tests();
        int          fd;
        int          n;
        logic [5:0]  func_v;
        int          rd_v;
        int          rs1_v;
        int          rs2_v;
        int          use_v;
        word_t       imm_v;
        word_t       exp_v;
        logic [NAME_W-1:0] name_v;
        fd = $fopen("tb/dlx_ex_tests.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open tb/dlx_ex_tests.txt");
            error_count++;
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS)
        begin
            n = $fscanf(fd, "%s %h %d %d %d %h %d %h\n", name_v, func_v, rd_v, rs1_v,
                        rs2_v, imm_v, use_v, exp_v);
            if (n != 8)
            begin
                if (n > 0)
                begin
                    $display("malformed line after test %0d in the test file", num_tests);
                    error_count++;
                end
                break;
            end
            t_name[num_tests]    = name_v;
            t_func[num_tests]    = alu_func_e'(func_v);
            t_rd[num_tests]      = reg_idx_t'(rd_v);
            t_rs1[num_tests]     = reg_idx_t'(rs1_v);
            t_rs2[num_tests]     = reg_idx_t'(rs2_v);
            t_imm[num_tests]     = imm_v;
            t_use_imm[num_tests] = (use_v != 0);
            t_exp[num_tests]     = exp_v;
            num_tests++;
        end
        $fclose(fd);
        if (num_tests == 0)
        begin
            $display("no tests were read from the test file");
            error_count++;
        end
    endtask

    task automatic drive_test(input int idx);
        issue_valid   = 1'b1;
        issue_func    = t_func[idx];
        issue_rd      = t_rd[idx];
        issue_rs1     = t_rs1[idx];
        issue_rs2     = t_rs2[idx];
        issue_imm     = t_imm[idx];
        issue_use_imm = t_use_imm[idx];
    endtask

    // stall depends only on registered state and holds through the next edge
    task automatic wait_issue(input int idx, output logic timed_out);
        int cycles;
        cycles = 0;
        while (stall && cycles < STALL_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        timed_out = stall;
        if (timed_out)
        begin
            $display("timeout: stall stayed high while %0s waited to issue", t_name[idx]);
            error_count++;
        end
        else
        begin
            exp_idx_q.push_back(idx);
            if (is_mult(t_func[idx]))
                mult_count++;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_idx_q.size() > 0 && cycles < DRAIN_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (exp_idx_q.size() > 0)
        begin
            $display("timeout: %0d writebacks never arrived", exp_idx_q.size());
            error_count++;
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial
    begin : main_seq
        logic timed_out;
        rst_n         = 1'b0;
        issue_valid   = 1'b0;
        issue_func    = ADD;
        issue_rd      = '0;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_imm     = '0;
        issue_use_imm = 1'b0;
        num_tests     = 0;
        pass_count    = 0;
        fail_count    = 0;
        error_count   = 0;
        stall_cycles  = 0;
        mult_count    = 0;
        timed_out     = 1'b0;
        load_tests();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < num_tests && !timed_out; i++)
        begin
            @(negedge clk);
            drive_test(i);
            wait_issue(i, timed_out);
        end
        @(negedge clk);
        issue_valid = 1'b0;

        wait_drain();
        repeat (QUIET_CYCLES) @(negedge clk);   // window for stray writebacks
        if (mult_count > 0 && stall_cycles == 0)
        begin
            $display("stall never rose although multiplies were issued");
            error_count++;
        end

        $display("%0d of %0d tests passed, %0d wrong, %0d other errors",
                 pass_count, num_tests, fail_count, error_count);
        if (fail_count == 0 && error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
